// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_packet_decoder -f verilog.f \
	-o sim_packet_decoder > sim.log 2>&1 && ./obj_dir/sim_packet_decoder >> sim.log 2>&1
cat sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: src/packet_decoder.sv
// Top level of the receive-side packet decoder feeding the hash engine
`timescale 1ns/1ps

module packet_decoder #(
	parameter logic [6:0] DEVICE_ADDR = 7'h15,
	parameter int         BLOCK_BYTES = 16,
	parameter int         MAX_CREDITS = 2
) (
	input  logic                     clk,
	input  logic                     n_rst,
	input  pd_pkg::rx_byte_t         rx,
	input  logic                     credit_return,
	output logic                     transmit_ack,
	output logic                     transmit_nack,
	output logic                     host_ready,
	output logic                     quit_hash,
	output logic                     p_error,
	output logic                     block_valid,
	output logic [BLOCK_BYTES*8-1:0] block
);

	pd_pkg::wr_byte_t wr;
	logic [pd_pkg::INDEX_W-1:0] index;
	logic cnt_up;
	logic clr_cnt;
	logic half_done;
	logic block_done;
	logic block_pending;

	// Block must split into two equal halves and fit the index
	if (BLOCK_BYTES < 4 || BLOCK_BYTES > 128 || BLOCK_BYTES % 2 != 0) begin : g_bad_size
		$error("BLOCK_BYTES must be even and between 4 and 128");
	end

	pd_controller #(.DEVICE_ADDR(DEVICE_ADDR)) u_controller (
		.clk           (clk),
		.n_rst         (n_rst),
		.rx            (rx),
		.index         (index),
		.half_done     (half_done),
		.block_pending (block_pending),
		.wr            (wr),
		.cnt_up        (cnt_up),
		.clr_cnt       (clr_cnt),
		.block_done    (block_done),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.host_ready    (host_ready),
		.quit_hash     (quit_hash),
		.p_error       (p_error)
	);

	pd_byte_counter #(.BLOCK_BYTES(BLOCK_BYTES)) u_counter (
		.clk       (clk),
		.n_rst     (n_rst),
		.cnt_up    (cnt_up),
		.clr_cnt   (clr_cnt),
		.index     (index),
		.half_done (half_done)
	);

	pd_block_buffer #(.BLOCK_BYTES(BLOCK_BYTES), .MAX_CREDITS(MAX_CREDITS)) u_buffer (
		.clk           (clk),
		.n_rst         (n_rst),
		.wr            (wr),
		.block_done    (block_done),
		.credit_return (credit_return),
		.block_pending (block_pending),
		.block_valid   (block_valid),
		.block         (block)
	);

endmodule

// File: src/pd_block_buffer.sv
// Assembles message blocks byte by byte and hands them to the hash engine under credits
`timescale 1ns/1ps

module pd_block_buffer #(
	parameter int BLOCK_BYTES = 16,
	parameter int MAX_CREDITS = 2
) (
	input  logic                       clk,
	input  logic                       n_rst,
	input  pd_pkg::wr_byte_t           wr,
	input  logic                       block_done,
	input  logic                       credit_return,
	output logic                       block_pending,
	output logic                       block_valid,
	output logic [BLOCK_BYTES*8-1:0]   block
);

	localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(MAX_CREDITS);

	logic [BLOCK_BYTES*8-1:0] block_q;
	logic [CREDIT_W-1:0] credits;

	// Byte 0 sits in the lowest lane
	always_ff @(posedge clk) begin
		if (wr.en)
			block_q[8 * wr.index +: 8] <= wr.data;
	end

	assign block = block_q;

	// A finished block waits here until a credit is available
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			block_pending <= 1'b0;
		else if (block_done)
			block_pending <= 1'b1;
		else if (block_valid)
			block_pending <= 1'b0;
	end

	// One cycle issue pulse, clears pending in the same cycle
	assign block_valid = block_pending && (credits != '0);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			credits <= CREDIT_FULL;
		end else begin
			case ({block_valid, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Controller must NACK data while a block is still held
	a_no_write_pending: assert property (@(posedge clk) disable iff (!n_rst)
		(wr.en || block_done) |-> !block_pending);

	// Engine returns a credit only for a block it has received
	a_no_credit_overflow: assert property (@(posedge clk) disable iff (!n_rst)
		credit_return |-> credits != CREDIT_FULL);

endmodule

// File: src/pd_byte_counter.sv
// Payload byte index for block assembly, flags the last byte of each half block
`timescale 1ns/1ps

module pd_byte_counter #(
	parameter int BLOCK_BYTES = 16
) (
	input  logic                       clk,
	input  logic                       n_rst,
	input  logic                       cnt_up,
	input  logic                       clr_cnt,
	output logic [pd_pkg::INDEX_W-1:0] index,
	output logic                       half_done
);

	localparam int IW = pd_pkg::INDEX_W;
	localparam logic [IW-1:0] LAST = IW'(BLOCK_BYTES - 1);
	localparam logic [IW-1:0] HALF_LAST = IW'(BLOCK_BYTES / 2 - 1);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			index <= '0;
		end else if (clr_cnt) begin
			index <= '0;
		end else if (cnt_up) begin
			// Wrap after the final byte of the block
			if (index == LAST)
				index <= '0;
			else
				index <= index + 1'b1;
		end
	end

	assign half_done = (index == HALF_LAST) || (index == LAST);

	a_index_range: assert property (@(posedge clk) disable iff (!n_rst)
		index <= LAST);

endmodule

// File: src/pd_controller.sv
// Packet decoding FSM: walks tokens and data packets, drives buffer writes and responses
`timescale 1ns/1ps

module pd_controller #(
	parameter logic [6:0] DEVICE_ADDR = 7'h15
) (
	input  logic                         clk,
	input  logic                         n_rst,
	input  pd_pkg::rx_byte_t             rx,
	input  logic [pd_pkg::INDEX_W-1:0]   index,
	input  logic                         half_done,
	input  logic                         block_pending,
	output pd_pkg::wr_byte_t             wr,
	output logic                         cnt_up,
	output logic                         clr_cnt,
	output logic                         block_done,
	output logic                         transmit_ack,
	output logic                         transmit_nack,
	output logic                         host_ready,
	output logic                         quit_hash,
	output logic                         p_error
);

	pd_pkg::pd_state_t state;
	pd_pkg::pd_state_t next_state;

	logic [7:0] byte_q;
	logic out_seen;
	logic out_seen_set;
	logic out_seen_clr;
	logic wr_en;
	logic in_packet;
	logic is_data_pid;

	// Last received byte, examined one cycle after its strobe
	always_ff @(posedge clk) begin
		if (rx.valid)
			byte_q <= rx.data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= pd_pkg::IDLE;
			out_seen <= 1'b0;
		end else begin
			state <= next_state;
			if (out_seen_set)
				out_seen <= 1'b1;
			else if (out_seen_clr)
				out_seen <= 1'b0;
		end
	end

	assign wr = '{en: wr_en, index: index, data: byte_q};

	assign is_data_pid = (byte_q == pd_pkg::DATA0) || (byte_q == pd_pkg::DATA1);

	// States where a receive error aborts the packet
	assign in_packet = !(state inside {pd_pkg::IDLE, pd_pkg::SKIP_EOP_WAIT, pd_pkg::NEW_BLOCK,
		pd_pkg::ERROR, pd_pkg::ERROR_EOP_WAIT, pd_pkg::ERROR_EOP_END,
		pd_pkg::TRANSMIT_ACK, pd_pkg::TRANSMIT_NACK, pd_pkg::HOST_READY});

	always_comb begin
		next_state = state;
		wr_en = 1'b0;
		cnt_up = 1'b0;
		clr_cnt = 1'b0;
		block_done = 1'b0;
		transmit_ack = 1'b0;
		transmit_nack = 1'b0;
		host_ready = 1'b0;
		quit_hash = 1'b0;
		p_error = 1'b0;
		out_seen_set = 1'b0;
		out_seen_clr = 1'b0;

		case (state)
			pd_pkg::IDLE: begin
				if (rx.valid)
					next_state = rx.error ? pd_pkg::ERROR : pd_pkg::READ_PID;
			end
			pd_pkg::READ_PID: begin
				if (byte_q[3:0] != ~byte_q[7:4])
					next_state = pd_pkg::ERROR;
				else if (byte_q == pd_pkg::IN_TOKEN)
					next_state = pd_pkg::IN_ADDR_WAIT;
				else if (byte_q == pd_pkg::OUT_TOKEN)
					next_state = pd_pkg::OUT_ADDR_WAIT;
				else if (is_data_pid && out_seen && block_pending)
					next_state = pd_pkg::ERROR;
				else if (byte_q == pd_pkg::DATA0 && out_seen)
					next_state = pd_pkg::CMD_WAIT;
				else if (byte_q == pd_pkg::DATA1 && out_seen)
					next_state = pd_pkg::HALF2_WAIT;
				else
					next_state = pd_pkg::SKIP_EOP_WAIT;
			end
			pd_pkg::IN_ADDR_WAIT: begin
				if (rx.valid)
					next_state = pd_pkg::IN_ADDR_CHECK;
				else if (rx.eop)
					next_state = pd_pkg::IDLE;
			end
			pd_pkg::IN_ADDR_CHECK: begin
				if (byte_q[6:0] == DEVICE_ADDR)
					next_state = pd_pkg::IN_EOP_WAIT;
				else
					next_state = pd_pkg::SKIP_EOP_WAIT;
			end
			pd_pkg::IN_EOP_WAIT: begin
				if (rx.eop)
					next_state = pd_pkg::IN_EOP_END;
			end
			pd_pkg::IN_EOP_END: begin
				if (!rx.eop)
					next_state = pd_pkg::HOST_READY;
			end
			pd_pkg::HOST_READY: begin
				host_ready = 1'b1;
				next_state = pd_pkg::IDLE;
			end
			pd_pkg::OUT_ADDR_WAIT: begin
				if (rx.valid)
					next_state = pd_pkg::OUT_ADDR_CHECK;
				else if (rx.eop)
					next_state = pd_pkg::IDLE;
			end
			pd_pkg::OUT_ADDR_CHECK: begin
				// An OUT to another device disarms the data path
				out_seen_set = (byte_q[6:0] == DEVICE_ADDR);
				out_seen_clr = (byte_q[6:0] != DEVICE_ADDR);
				next_state = pd_pkg::SKIP_EOP_WAIT;
			end
			pd_pkg::SKIP_EOP_WAIT: begin
				if (rx.eop)
					next_state = pd_pkg::IDLE;
			end
			pd_pkg::CMD_WAIT: begin
				if (rx.valid)
					next_state = pd_pkg::CMD_CHECK;
				else if (rx.eop)
					next_state = pd_pkg::ERROR;
			end
			pd_pkg::CMD_CHECK: begin
				if (byte_q == pd_pkg::CMD_INTERRUPT) begin
					next_state = pd_pkg::INTERRUPT;
				end else if (byte_q == pd_pkg::CMD_HASH) begin
					clr_cnt = 1'b1;
					next_state = pd_pkg::HALF1_WAIT;
				end else begin
					next_state = pd_pkg::ERROR;
				end
			end
			pd_pkg::INTERRUPT: begin
				quit_hash = 1'b1;
				next_state = pd_pkg::DATA_EOP_WAIT;
			end
			pd_pkg::HALF1_WAIT: begin
				if (rx.valid)
					next_state = pd_pkg::HALF1_WRITE;
				else if (rx.eop)
					next_state = pd_pkg::ERROR;
			end
			pd_pkg::HALF1_WRITE: begin
				wr_en = 1'b1;
				cnt_up = 1'b1;
				next_state = half_done ? pd_pkg::DATA_EOP_WAIT : pd_pkg::HALF1_WAIT;
			end
			pd_pkg::HALF2_WAIT: begin
				if (rx.valid)
					next_state = pd_pkg::HALF2_WRITE;
				else if (rx.eop)
					next_state = pd_pkg::ERROR;
			end
			pd_pkg::HALF2_WRITE: begin
				wr_en = 1'b1;
				cnt_up = 1'b1;
				next_state = half_done ? pd_pkg::BLOCK_EOP_WAIT : pd_pkg::HALF2_WAIT;
			end
			pd_pkg::DATA_EOP_WAIT: begin
				if (rx.eop)
					next_state = pd_pkg::ACK_EOP_END;
			end
			pd_pkg::BLOCK_EOP_WAIT: begin
				if (rx.eop)
					next_state = pd_pkg::NEW_BLOCK;
			end
			pd_pkg::NEW_BLOCK: begin
				block_done = 1'b1;
				clr_cnt = 1'b1;
				next_state = rx.eop ? pd_pkg::ACK_EOP_END : pd_pkg::TRANSMIT_ACK;
			end
			pd_pkg::ACK_EOP_END: begin
				if (!rx.eop)
					next_state = pd_pkg::TRANSMIT_ACK;
			end
			pd_pkg::TRANSMIT_ACK: begin
				transmit_ack = 1'b1;
				next_state = pd_pkg::IDLE;
			end
			pd_pkg::ERROR: begin
				p_error = 1'b1;
				clr_cnt = 1'b1;
				next_state = pd_pkg::ERROR_EOP_WAIT;
			end
			pd_pkg::ERROR_EOP_WAIT: begin
				if (rx.eop)
					next_state = pd_pkg::ERROR_EOP_END;
			end
			pd_pkg::ERROR_EOP_END: begin
				if (!rx.eop)
					next_state = pd_pkg::TRANSMIT_NACK;
			end
			pd_pkg::TRANSMIT_NACK: begin
				transmit_nack = 1'b1;
				next_state = pd_pkg::IDLE;
			end
			default: next_state = pd_pkg::IDLE;
		endcase

		// Receive error forces the NACK path
		if (rx.error && in_packet)
			next_state = pd_pkg::ERROR;
	end

	a_one_response: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0({transmit_ack, transmit_nack, host_ready}));

	a_no_write_idle: assert property (@(posedge clk) disable iff (!n_rst)
		state == pd_pkg::IDLE |-> !wr.en);

endmodule

// File: src/pd_pkg.sv
// Shared PID, command and state encodings plus the bus structs of the packet decoder
package pd_pkg;

	// Index width bounds the block at 128 bytes
	localparam int INDEX_W = 7;

	// Accepted PID bytes, low nibble is the complement of the high nibble
	typedef enum logic [7:0] {
		IN_TOKEN  = 8'h69,
		OUT_TOKEN = 8'hE1,
		DATA0     = 8'hC3,
		DATA1     = 8'h4B
	} pid_t;

	// First payload byte of a DATA0 packet
	typedef enum logic [7:0] {
		CMD_INTERRUPT = 8'h00,
		CMD_HASH      = 8'h01
	} cmd_t;

	typedef enum logic [5:0] {
		IDLE,
		READ_PID,
		IN_ADDR_WAIT,
		IN_ADDR_CHECK,
		IN_EOP_WAIT,
		IN_EOP_END,
		HOST_READY,
		OUT_ADDR_WAIT,
		OUT_ADDR_CHECK,
		SKIP_EOP_WAIT,
		CMD_WAIT,
		CMD_CHECK,
		INTERRUPT,
		HALF1_WAIT,
		HALF1_WRITE,
		HALF2_WAIT,
		HALF2_WRITE,
		DATA_EOP_WAIT,
		BLOCK_EOP_WAIT,
		NEW_BLOCK,
		ACK_EOP_END,
		TRANSMIT_ACK,
		ERROR,
		ERROR_EOP_WAIT,
		ERROR_EOP_END,
		TRANSMIT_NACK
	} pd_state_t;

	// Byte stream from the receiver, eop is a level
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       eop;
		logic       error;
	} rx_byte_t;

	typedef struct packed {
		logic               en;
		logic [INDEX_W-1:0] index;
		logic [7:0]         data;
	} wr_byte_t;

endpackage

// File: verification/tb_packet_tasks.svh
// Directed packet tests for the packet decoder, included inside the testbench top module
`ifndef TB_PACKET_TASKS_SVH
`define TB_PACKET_TASKS_SVH

	// One byte strobe, then one idle cycle
	task automatic send_byte(input logic [7:0] value, input logic err);
		rx.valid = 1'b1;
		rx.data = value;
		rx.error = err;
		@(negedge clk);
		rx = '0;
		@(negedge clk);
	endtask

	task automatic send_packet(input logic [7:0] pid, input bytes_t data, input int err_at);
		send_byte(pid, 1'b0);
		foreach (data[i])
			send_byte(data[i], i == err_at);
		rx.eop = 1'b1;
		repeat (2) @(negedge clk);
		rx.eop = 1'b0;
	endtask

	task automatic send_checked(input logic [7:0] pid, input bytes_t data, input int err_at,
		input resp_t expected);
		mark_counts();
		send_packet(pid, data, err_at);
		check_response(expected);
	endtask

	task automatic send_token(input logic [7:0] pid, input logic [6:0] addr,
		input resp_t expected);
		bytes_t addr_byte;
		addr_byte = {};
		addr_byte.push_back({1'b0, addr});
		send_checked(pid, addr_byte, -1, expected);
	endtask

	// OUT token, then a hash block split over DATA0 and DATA1
	task automatic send_block(output block_t expected);
		bytes_t first;
		bytes_t second;
		random_bytes(HALF_BYTES, first);
		random_bytes(HALF_BYTES, second);
		expected = '0;
		foreach (first[i])
			expected[8*i +: 8] = first[i];
		foreach (second[i])
			expected[8*(HALF_BYTES+i) +: 8] = second[i];
		send_token(pd_pkg::OUT_TOKEN, DEVICE_ADDR, RESP_NONE);
		first.push_front(pd_pkg::CMD_HASH);
		send_checked(pd_pkg::DATA0, first, -1, RESP_ACK);
		send_checked(pd_pkg::DATA1, second, -1, RESP_ACK);
	endtask

	task automatic test_reset_state();
		test_name = "reset";
		check_bit("transmit_ack", 1'b0, transmit_ack);
		check_bit("transmit_nack", 1'b0, transmit_nack);
		check_bit("host_ready", 1'b0, host_ready);
		check_bit("quit_hash", 1'b0, quit_hash);
		check_bit("p_error", 1'b0, p_error);
		check_bit("block_valid", 1'b0, block_valid);
	endtask

	task automatic test_tokens();
		test_name = "tokens";
		send_token(pd_pkg::IN_TOKEN, DEVICE_ADDR, RESP_HOST);
		check_count("quit_hash pulses", 0, quit_count - quit_base);
		check_count("p_error pulses", 0, perr_count - perr_base);
		send_token(pd_pkg::IN_TOKEN, OTHER_ADDR, RESP_NONE);
		send_token(pd_pkg::OUT_TOKEN, OTHER_ADDR, RESP_NONE);
		check_count("block_valid pulses", 0, blocks_q.size());
	endtask

	task automatic test_hash_block();
		block_t sent;
		int base;
		test_name = "hash_block";
		base = blocks_q.size();
		send_block(sent);
		wait_blocks(base + 1);
		repeat (RESP_WINDOW) @(negedge clk);
		check_count("block_valid pulses", base + 1, blocks_q.size());
		check_block("block", sent, blocks_q[base]);
		return_credit();
	endtask

	task automatic test_interrupt_unarmed();
		bytes_t cmd;
		bytes_t half;
		int base;
		test_name = "interrupt";
		cmd = {};
		cmd.push_back(pd_pkg::CMD_INTERRUPT);
		send_token(pd_pkg::OUT_TOKEN, DEVICE_ADDR, RESP_NONE);
		send_checked(pd_pkg::DATA0, cmd, -1, RESP_ACK);
		check_count("quit_hash pulses", 1, quit_count - quit_base);
		// OUT to another device disarms the data path
		test_name = "unarmed_data1";
		base = blocks_q.size();
		send_token(pd_pkg::OUT_TOKEN, OTHER_ADDR, RESP_NONE);
		random_bytes(HALF_BYTES, half);
		send_checked(pd_pkg::DATA1, half, -1, RESP_NONE);
		check_count("block_valid pulses", base, blocks_q.size());
	endtask

	task automatic test_errors();
		bytes_t extra;
		bytes_t bad_cmd;
		test_name = "bad_pid";
		random_bytes(1, extra);
		send_checked(8'hC4, extra, -1, RESP_NACK);
		check_count("p_error pulses", 1, perr_count - perr_base);
		test_name = "bad_command";
		bad_cmd = {};
		bad_cmd.push_back(8'h7F);
		send_token(pd_pkg::OUT_TOKEN, DEVICE_ADDR, RESP_NONE);
		send_checked(pd_pkg::DATA0, bad_cmd, -1, RESP_NACK);
		check_count("p_error pulses", 1, perr_count - perr_base);
		test_name = "rx_error";
		random_bytes(HALF_BYTES, extra);
		extra.push_front(pd_pkg::CMD_HASH);
		send_checked(pd_pkg::DATA0, extra, 3, RESP_NACK);
		check_count("p_error pulses", 1, perr_count - perr_base);
	endtask

	task automatic test_credit_flow();
		block_t sent[3];
		bytes_t payload;
		int base;
		int n;
		test_name = "credit_flow";
		base = blocks_q.size();
		for (n = 0; n < 3; n++)
			send_block(sent[n]);
		wait_blocks(base + 2);
		repeat (2 * RESP_WINDOW) @(negedge clk);
		check_count("blocks before credit return", base + 2, blocks_q.size());
		// Third block still held, so new data is refused
		random_bytes(HALF_BYTES, payload);
		payload.push_front(pd_pkg::CMD_HASH);
		send_checked(pd_pkg::DATA0, payload, -1, RESP_NACK);
		check_count("p_error pulses", 1, perr_count - perr_base);
		return_credit();
		wait_blocks(base + 3);
		for (n = 0; n < 3; n++)
			check_block($sformatf("block %0d", n), sent[n], blocks_q[base + n]);
	endtask

`endif

// File: verification/tb_packet_decoder.sv
// Directed testbench for the packet decoder, compiled as the simulation top with its task header
`timescale 1ns/1ps

module tb_packet_decoder;

	localparam logic [6:0] DEVICE_ADDR = 7'h15;
	localparam logic [6:0] OTHER_ADDR = 7'h2A;
	localparam int BLOCK_BYTES = 16;
	localparam int HALF_BYTES = BLOCK_BYTES / 2;
	localparam int MAX_CREDITS = 2;
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int RESP_WINDOW = 4;
	localparam int BLOCK_WAIT = 20;

	typedef enum {RESP_NONE, RESP_ACK, RESP_NACK, RESP_HOST, RESP_MIXED} resp_t;
	typedef logic [BLOCK_BYTES*8-1:0] block_t;
	typedef logic [7:0] bytes_t[$];

	logic clk;
	logic n_rst;
	pd_pkg::rx_byte_t rx;
	logic credit_return;
	logic transmit_ack;
	logic transmit_nack;
	logic host_ready;
	logic quit_hash;
	logic p_error;
	logic block_valid;
	block_t block;

	logic [31:0] lfsr = 32'he482_5602;
	int cycles = 0;
	int errors = 0;
	string test_name = "reset";

	// Pulse counters and issued blocks, written only by the monitor
	int ack_count = 0;
	int nack_count = 0;
	int host_count = 0;
	int quit_count = 0;
	int perr_count = 0;
	block_t blocks_q[$];

	// Counter values at the start of the current packet
	int ack_base;
	int nack_base;
	int host_base;
	int quit_base;
	int perr_base;

	packet_decoder #(
		.DEVICE_ADDR (DEVICE_ADDR),
		.BLOCK_BYTES (BLOCK_BYTES),
		.MAX_CREDITS (MAX_CREDITS)
	) UUT (
		.clk           (clk),
		.n_rst         (n_rst),
		.rx            (rx),
		.credit_return (credit_return),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.host_ready    (host_ready),
		.quit_hash     (quit_hash),
		.p_error       (p_error),
		.block_valid   (block_valid),
		.block         (block)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Sampled at the rising edge, before the state register moves on
	always @(posedge clk) begin
		if (n_rst) begin
			if (transmit_ack)
				ack_count++;
			if (transmit_nack)
				nack_count++;
			if (host_ready)
				host_count++;
			if (quit_hash)
				quit_count++;
			if (p_error)
				perr_count++;
			if (block_valid)
				blocks_q.push_back(block);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles in test %s", cycles, test_name);
			$display(">>> FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] value);
		return value[0] ? ((value >> 1) ^ 32'h8020_0003) : (value >> 1);
	endfunction

	task automatic random_bytes(input int count, output bytes_t bytes);
		logic [7:0] value;
		int bit_i;
		bytes = {};
		value = '0;
		repeat (count) begin
			for (bit_i = 0; bit_i < 8; bit_i++) begin
				value = {value[6:0], lfsr[0]};
				lfsr = lfsr_step(lfsr);
			end
			bytes.push_back(value);
		end
	endtask

	task automatic fail_now(input string msg);
		errors++;
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			fail_now($sformatf("[FAIL] %s: %s expected %b actual %b",
				test_name, what, expected, actual));
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected)
			fail_now($sformatf("[FAIL] %s: %s expected %0d actual %0d",
				test_name, what, expected, actual));
	endtask

	task automatic check_block(input string what, input block_t expected, input block_t actual);
		if (actual !== expected)
			fail_now($sformatf("[FAIL] %s: %s expected %h actual %h",
				test_name, what, expected, actual));
	endtask

	task automatic mark_counts();
		ack_base = ack_count;
		nack_base = nack_count;
		host_base = host_count;
		quit_base = quit_count;
		perr_base = perr_count;
	endtask

	function automatic resp_t observed_response();
		int acks;
		int nacks;
		int hosts;
		acks = ack_count - ack_base;
		nacks = nack_count - nack_base;
		hosts = host_count - host_base;
		if (acks + nacks + hosts > 1)
			return RESP_MIXED;
		if (acks == 1)
			return RESP_ACK;
		if (nacks == 1)
			return RESP_NACK;
		if (hosts == 1)
			return RESP_HOST;
		return RESP_NONE;
	endfunction

	// Waits for a response pulse until the window after eop closes
	task automatic check_response(input resp_t expected);
		resp_t actual;
		int waited;
		waited = 0;
		while (waited < RESP_WINDOW && observed_response() == RESP_NONE) begin
			@(negedge clk);
			waited++;
		end
		actual = observed_response();
		if (actual != expected)
			fail_now($sformatf("[FAIL] %s: response expected %s actual %s",
				test_name, expected.name(), actual.name()));
	endtask

	task automatic wait_blocks(input int total);
		int waited;
		waited = 0;
		while (blocks_q.size() < total) begin
			if (waited == BLOCK_WAIT)
				fail_now($sformatf("%s: block_valid never pulsed for block %0d",
					test_name, total - 1));
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic return_credit();
		credit_return = 1'b1;
		@(negedge clk);
		credit_return = 1'b0;
	endtask

	`include "tb_packet_tasks.svh"

	initial begin
		rx = '0;
		credit_return = 1'b0;
		n_rst = 1'b0;
		repeat (4) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		test_reset_state();
		test_tokens();
		test_hash_block();
		test_interrupt_unarmed();
		test_errors();
		test_credit_flow();
		if (errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			fail_now("errors were recorded during the run");
		end
	end

endmodule

// File: verilog.f
+incdir+verification
src/pd_pkg.sv
src/pd_controller.sv
src/pd_byte_counter.sv
src/pd_block_buffer.sv
src/packet_decoder.sv
verification/tb_packet_decoder.sv
